//--- Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = hist_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hist_pkg.sv
hist_bank_if.sv
frame_sequencer.sv
hist_bank.sv
hist_builder.sv
hist_readout.sv
hist_top.sv
tb_clock_gen.sv
hist_tb.sv

//--- frame_sequencer.sv
`timescale 1ns/1ns

module frame_sequencer import hist_pkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   wr_en,
    output pixel_t pixel_idx,
    output logic   last_sample,
    output logic   frame_done
);

    // sample within slot, pixel slot, acquisition
    logic [DATA_W-1:0] data_cnt;
    pixel_t            pix_cnt;
    logic [ACQ_W-1:0]  acq_cnt;

    // each counter sitting on its last value
    logic data_end;
    logic pix_end;
    logic acq_end;

    assign data_end = (data_cnt == DATA_W'(DATA_NUM - 1));
    assign pix_end  = (pix_cnt == PIXEL_W'(PIXEL_NUM - 1));
    assign acq_end  = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // final sample of the frame, only while it is being written
    assign last_sample = wr_en && data_end && pix_end && acq_end;

    assign pixel_idx = pix_cnt;

    // nested counters, step only on accepted samples
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            data_cnt <= '0;
            pix_cnt  <= '0;
            acq_cnt  <= '0;
        end else if (wr_en) begin
            if (data_end) begin
                data_cnt <= '0;
                if (pix_end) begin
                    pix_cnt <= '0;
                    // wraps to 0 on last sample, so all counters clear together
                    if (acq_end) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    // one-cycle pulse after the frame's last write
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= last_sample;
        end
    end

endmodule

//--- hist_bank.sv
`timescale 1ns/1ns

module hist_bank import hist_pkg::*; (
    input  logic           clk,
    input  logic           combin_res,
    hist_bank_if.bank      port,
    input  logic           last_sample,
    input  addr_t          scan_addr,
    output count_t         scan_rd_count,
    output logic           scan_rd_hit,
    output logic           his_num
);

    // two banks of bin counters
    count_t mem [2][ENTRY_NUM];

    // per-entry hit flags, one vector per bank
    logic [1:0][ENTRY_NUM-1:0] hit;

    // bank being read out, the one not filling
    logic scan_bank;

    assign scan_bank = ~his_num;

    // builder side reads the filling bank
    assign port.rd_count = mem[his_num][port.addr];
    assign port.rd_hit   = hit[his_num][port.addr];

    // readout side reads the completed bank
    assign scan_rd_count = mem[scan_bank][scan_addr];
    assign scan_rd_hit   = hit[scan_bank][scan_addr];

    // count storage, stale values masked by hit flags
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[his_num][port.addr] <= port.wr_count;
        end
    end

    // flags and bank select
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            his_num <= 1'b0;
            hit     <= '0;
        end else begin
            // mark entry touched in the filling bank
            if (port.wr_en) begin
                hit[his_num][port.addr] <= 1'b1;
            end
            // frame end: swap banks
            // the bank about to fill starts empty in one cycle
            // completed bank keeps its flags for readout
            if (last_sample) begin
                his_num        <= ~his_num;
                hit[scan_bank] <= '0;
            end
        end
    end

endmodule

//--- hist_bank_if.sv
`timescale 1ns/1ns

// read-modify-write path from builder into the active bank
interface hist_bank_if import hist_pkg::*; ();

    // write strobe, one per accepted sample
    logic wr_en;
    // entry address, also the read address
    addr_t addr;
    // count to store
    count_t wr_count;

    // combinational read of the active bank
    count_t rd_count;
    // entry already touched this frame
    logic rd_hit;

    modport builder (
        output wr_en,
        output addr,
        output wr_count,
        input  rd_count,
        input  rd_hit
    );

    modport bank (
        input  wr_en,
        input  addr,
        input  wr_count,
        output rd_count,
        output rd_hit
    );

endinterface

//--- hist_builder.sv
`timescale 1ns/1ns

module hist_builder import hist_pkg::*; (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           wr_en,
    input  bin_t           bin_code,
    input  pixel_t         pixel_idx,
    hist_bank_if.builder   bank,
    output count_t         bin_count,
    output logic           count_valid
);

    // incremented count for the addressed entry
    count_t new_count;

    // pixel * BIN_NUM + bin, BIN_NUM is a power of two
    assign bank.addr = {pixel_idx, bin_code};

    // untouched entry restarts at 1, whatever the array holds
    always_comb begin
        if (bank.rd_hit) begin
            new_count = bank.rd_count + COUNT_W'(1);
        end else begin
            new_count = COUNT_W'(1);
        end
    end

    // write back on the accepting edge
    assign bank.wr_en    = wr_en;
    assign bank.wr_count = new_count;

    // running count of this bin, seen one cycle later
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bin_count <= new_count;
        end
    end

    // strobe for bin_count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            count_valid <= 1'b0;
        end else begin
            count_valid <= wr_en;
        end
    end

endmodule

//--- hist_patterns.txt
// word 0: frame count; per frame: 64 bin codes (sample 0 leftmost),
// 64 gap flags (sample 0 is the top bit), 4 expected peak bins (pixel 0 leftmost)
3
335377870000ffe1335377870000ffe1335377870000ffe1335377870000ffe1
ffffffffffffffff
370f
9a9a4444c2c256789a9a4444c2c256789a9a4444c2c256789a9a4444c2c25678
0000000000000000
9425
333377770000eeee333577780001eeef335577880011eeff355578880111efff
f0f0f0f0a5a5a5a5
370e

//--- hist_pkg.sv
package hist_pkg;

    // tdc code width, one histogram per pixel
    localparam int BIN_W = 4;
    localparam int BIN_NUM = 2 ** BIN_W;

    // pixel slots per acquisition
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W = 2;

    // samples per pixel slot
    localparam int DATA_NUM = 4;
    localparam int DATA_W = 2;

    // acquisitions accumulated into one frame
    localparam int ACQ_NUM = 4;
    localparam int ACQ_W = 2;

    // entries per bank, pixel-major
    localparam int ENTRY_NUM = PIXEL_NUM * BIN_NUM;
    localparam int ADDR_W = 6;

    // max count is DATA_NUM * ACQ_NUM = 16, so no saturation logic
    localparam int COUNT_W = 6;

    // tdc bin code
    typedef logic [BIN_W-1:0] bin_t;

    // pixel slot index
    typedef logic [PIXEL_W-1:0] pixel_t;

    // bank entry address, {pixel, bin}
    typedef logic [ADDR_W-1:0] addr_t;

    // photon count of one bin
    typedef logic [COUNT_W-1:0] count_t;

endpackage

//--- hist_readout.sv
`timescale 1ns/1ns

module hist_readout import hist_pkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   frame_done,
    output addr_t  scan_addr,
    input  count_t scan_rd_count,
    input  logic   scan_rd_hit,
    output logic   scan_valid,
    output pixel_t scan_pixel,
    output bin_t   scan_bin,
    output count_t scan_count,
    output logic   peak_valid,
    output pixel_t peak_pixel,
    output bin_t   peak_bin,
    output count_t peak_count
);

    // scan in progress
    logic scan_busy;

    // entry currently addressed
    pixel_t cur_pixel;
    bin_t   cur_bin;
    count_t cur_count;

    // running max of the current pixel
    count_t run_max;
    bin_t   run_bin;

    // max including the current entry
    count_t best_count;
    bin_t   best_bin;

    assign cur_pixel = scan_addr[ADDR_W-1:BIN_W];
    assign cur_bin   = scan_addr[BIN_W-1:0];

    // cleared flag means no hits this frame
    assign cur_count = scan_rd_hit ? scan_rd_count : '0;

    // bin 0 restarts the max
    // strictly larger only, ties keep lowest bin
    always_comb begin
        if ((cur_bin == '0) || (cur_count > run_max)) begin
            best_count = cur_count;
            best_bin   = cur_bin;
        end else begin
            best_count = run_max;
            best_bin   = run_bin;
        end
    end

    // address counter, ENTRY_NUM cycles per frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            scan_busy <= 1'b0;
            scan_addr <= '0;
        end else if (frame_done) begin
            scan_busy <= 1'b1;
            scan_addr <= '0;
        end else if (scan_busy) begin
            // wraps back to 0 after the last entry
            scan_addr <= scan_addr + 1'b1;
            if (scan_addr == ADDR_W'(ENTRY_NUM - 1)) begin
                scan_busy <= 1'b0;
            end
        end
    end

    // stream and peak strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            scan_valid <= 1'b0;
            peak_valid <= 1'b0;
        end else begin
            scan_valid <= scan_busy;
            peak_valid <= scan_busy && (cur_bin == BIN_W'(BIN_NUM - 1));
        end
    end

    // payload, one cycle behind scan_addr
    always_ff @(posedge clk) begin
        if (scan_busy) begin
            scan_pixel <= cur_pixel;
            scan_bin   <= cur_bin;
            scan_count <= cur_count;
            run_max    <= best_count;
            run_bin    <= best_bin;
            // publish on the pixel's last bin
            if (cur_bin == BIN_W'(BIN_NUM - 1)) begin
                peak_pixel <= cur_pixel;
                peak_bin   <= best_bin;
                peak_count <= best_count;
            end
        end
    end

endmodule

//--- hist_tb.sv
`timescale 1ns/1ns

module hist_tb import hist_pkg::*; ();

    logic   clk;
    logic   combin_res;
    logic   wr_en;
    bin_t   bin_code;
    count_t bin_count;
    logic   count_valid;
    logic   frame_done;
    logic   his_num;
    logic   scan_valid;
    pixel_t scan_pixel;
    bin_t   scan_bin;
    count_t scan_count;
    logic   peak_valid;
    pixel_t peak_pixel;
    bin_t   peak_bin;
    count_t peak_count;

    // word 0 holds the frame count
    // each frame then takes codes, gap flags and peaks
    logic [255:0] pat_mem [10];

    // reference model with two banks and the bank select
    int          model_bank [2][ENTRY_NUM];
    logic        model_his;
    int          sample_idx;
    logic        exp_cv;
    int          exp_count;
    logic        exp_fd;
    // expected peaks of the frame being driven
    logic [15:0] cur_peaks = '0;
    // expected peaks of the last completed frame
    logic [15:0] done_peaks = '0;
    // completed bank and peaks as seen by the running readout
    int          scan_model [ENTRY_NUM];
    logic [15:0] scan_peaks = '0;
    // scan position or -1 when no readout is running
    int          scan_idx = -1;
    logic        scan_wait;
    // frame_done pulses seen since the start
    int          fd_cnt = 0;

    int check_cnt = 0;
    int err_cnt = 0;
    int abort_cnt = 0;

    tb_clock_gen clk_gen (.clk(clk));

    hist_top uut (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .bin_code    (bin_code),
        .bin_count   (bin_count),
        .count_valid (count_valid),
        .frame_done  (frame_done),
        .his_num     (his_num),
        .scan_valid  (scan_valid),
        .scan_pixel  (scan_pixel),
        .scan_bin    (scan_bin),
        .scan_count  (scan_count),
        .peak_valid  (peak_valid),
        .peak_pixel  (peak_pixel),
        .peak_bin    (peak_bin),
        .peak_count  (peak_count)
    );

    function automatic int frame_len();
        return DATA_NUM * PIXEL_NUM * ACQ_NUM;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("checks %0d, errors %0d, aborts %0d", check_cnt, err_cnt, abort_cnt);
        if (err_cnt == 0 && abort_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // lowest bin holding the largest count
    function automatic int model_peak_bin(input int pixel);
        int b;
        int best;
        best = 0;
        for (b = 1; b < BIN_NUM; b++) begin
            if (scan_model[pixel * BIN_NUM + b] > scan_model[pixel * BIN_NUM + best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    task automatic reset_model();
        int a;
        for (a = 0; a < ENTRY_NUM; a++) begin
            model_bank[0][a] = 0;
            model_bank[1][a] = 0;
        end
        model_his = 1'b0;
        sample_idx = 0;
        exp_cv = 1'b0;
        exp_fd = 1'b0;
        exp_count = 0;
        scan_idx = -1;
        scan_wait = 1'b0;
    endtask

    // sample taken at the coming rising edge
    task automatic accept_sample(input bin_t code);
        int pixel;
        int addr;
        int a;
        pixel = (sample_idx / DATA_NUM) % PIXEL_NUM;
        addr = pixel * BIN_NUM + int'(code);
        model_bank[model_his][addr] += 1;
        exp_count = model_bank[model_his][addr];
        exp_cv = 1'b1;
        sample_idx++;
        // frame end swaps banks and empties the new one
        if (sample_idx == frame_len()) begin
            sample_idx = 0;
            exp_fd = 1'b1;
            model_his = ~model_his;
            for (a = 0; a < ENTRY_NUM; a++) begin
                model_bank[model_his][a] = 0;
            end
            done_peaks = cur_peaks;
        end
    endtask

    // freeze the completed bank for the readout
    // the next frame may end before the last entry
    task automatic capture_scan();
        int a;
        for (a = 0; a < ENTRY_NUM; a++) begin
            scan_model[a] = model_bank[model_his ? 0 : 1][a];
        end
        scan_peaks = done_peaks;
    endtask

    task automatic check_scan_entry();
        int pixel;
        int bin;
        int pk;
        pixel = scan_idx / BIN_NUM;
        bin = scan_idx % BIN_NUM;
        check_val("scan_valid", int'(scan_valid), 1);
        check_val("scan_pixel", int'(scan_pixel), pixel);
        check_val("scan_bin", int'(scan_bin), bin);
        check_val("scan_count", int'(scan_count), scan_model[scan_idx]);
        // peak published with the pixel's last bin
        if (bin == BIN_NUM - 1) begin
            pk = model_peak_bin(pixel);
            check_val("peak_valid", int'(peak_valid), 1);
            check_val("peak_pixel", int'(peak_pixel), pixel);
            check_val("peak_bin", int'(peak_bin), pk);
            check_val("peak_bin (file)", int'(peak_bin), int'(scan_peaks[15 - 4 * pixel -: 4]));
            check_val("peak_count", int'(peak_count), scan_model[pixel * BIN_NUM + pk]);
        end else begin
            check_val("peak_valid", int'(peak_valid), 0);
        end
    endtask

    // all outputs checked mid-cycle where they are stable
    always @(negedge clk) begin
        if (!combin_res) begin
            check_val("count_valid", int'(count_valid), 0);
            check_val("frame_done", int'(frame_done), 0);
            check_val("his_num", int'(his_num), 0);
            check_val("scan_valid", int'(scan_valid), 0);
            check_val("peak_valid", int'(peak_valid), 0);
            reset_model();
        end else begin
            check_val("count_valid", int'(count_valid), int'(exp_cv));
            if (exp_cv) begin
                check_val("bin_count", int'(bin_count), exp_count);
            end
            check_val("frame_done", int'(frame_done), int'(exp_fd));
            check_val("his_num", int'(his_num), int'(model_his));
            if (frame_done) begin
                fd_cnt++;
            end
            if (scan_idx >= 0) begin
                check_scan_entry();
                scan_idx++;
                if (scan_idx == ENTRY_NUM) begin
                    scan_idx = -1;
                end
            end else begin
                check_val("scan_valid", int'(scan_valid), 0);
                check_val("peak_valid", int'(peak_valid), 0);
            end
            // first entry two cycles after frame_done
            if (scan_wait) begin
                scan_wait = 1'b0;
                scan_idx = 0;
                capture_scan();
            end
            if (exp_fd) begin
                scan_wait = 1'b1;
            end
            exp_cv = 1'b0;
            exp_fd = 1'b0;
            if (wr_en) begin
                accept_sample(bin_code);
            end
        end
    end

    // first n samples of pattern frame f
    // random idle cycles after flagged samples
    task automatic drive_frame(input int f, input int n);
        int s;
        int idle;
        logic [255:0] codes;
        logic [63:0] gaps;
        codes = pat_mem[1 + 3 * f];
        gaps = pat_mem[2 + 3 * f][63:0];
        cur_peaks = pat_mem[3 + 3 * f][15:0];
        for (s = 0; s < n; s++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            bin_code <= codes[255 - 4 * s -: 4];
            if (gaps[63 - s]) begin
                idle = $urandom % 4;
                repeat (idle) begin
                    @(posedge clk);
                    wr_en <= 1'b0;
                    // junk code that must not be counted
                    bin_code <= BIN_W'($urandom);
                end
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // target is the total number of frame_done pulses expected so far
    task automatic wait_frame_done(input int target);
        int n;
        n = 0;
        while (fd_cnt < target && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (fd_cnt < target) begin
            $display("timeout: frame_done did not pulse after the last sample of a frame");
            abort_cnt++;
        end
    endtask

    // readout ends with the last pixel's peak
    task automatic wait_readout_end();
        int n;
        logic seen;
        seen = 1'b0;
        n = 0;
        while (!seen && n < ENTRY_NUM + 16) begin
            @(negedge clk);
            seen = peak_valid && (peak_pixel == PIXEL_W'(PIXEL_NUM - 1));
            n++;
        end
        if (!seen) begin
            $display("timeout: readout never delivered the peak of the last pixel");
            abort_cnt++;
        end
    endtask

    task automatic reset_mid_frame();
        @(posedge clk);
        combin_res <= 1'b0;
        wr_en <= 1'b0;
        repeat (4) @(posedge clk);
        combin_res <= 1'b1;
    endtask

    task automatic run_frames(input int n_frames);
        int f;
        // frames back to back with readout overlapping the next frame
        for (f = 0; f < n_frames && abort_cnt == 0; f++) begin
            drive_frame(f, frame_len());
            wait_frame_done(f + 1);
        end
        if (abort_cnt == 0) begin
            wait_readout_end();
        end
        // partial frame then reset
        // the following full frame reads out as the first
        if (abort_cnt == 0) begin
            drive_frame(1, 20);
            reset_mid_frame();
            drive_frame(0, frame_len());
            wait_frame_done(n_frames + 1);
        end
        if (abort_cnt == 0) begin
            wait_readout_end();
        end
    endtask

    initial begin
        int n_frames;
        void'($urandom(211));
        combin_res <= 1'b0;
        wr_en <= 1'b0;
        bin_code <= '0;
        $readmemh("hist_patterns.txt", pat_mem);
        n_frames = int'(pat_mem[0][31:0]);
        if (n_frames < 2 || 3 * n_frames + 1 > $size(pat_mem)) begin
            $display("pattern file missing or holding a bad frame count");
            abort_cnt++;
        end else begin
            repeat (4) @(posedge clk);
            combin_res <= 1'b1;
            run_frames(n_frames);
            repeat (2) @(posedge clk);
        end
        end_run();
    end

endmodule

//--- hist_top.sv
`timescale 1ns/1ns

module hist_top import hist_pkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   wr_en,
    input  bin_t   bin_code,
    output count_t bin_count,
    output logic   count_valid,
    output logic   frame_done,
    output logic   his_num,
    output logic   scan_valid,
    output pixel_t scan_pixel,
    output bin_t   scan_bin,
    output count_t scan_count,
    output logic   peak_valid,
    output pixel_t peak_pixel,
    output bin_t   peak_bin,
    output count_t peak_count
);

    // sequencer outputs
    pixel_t pixel_idx;
    logic   last_sample;

    // readout scan port into the completed bank
    addr_t  scan_addr;
    count_t scan_rd_count;
    logic   scan_rd_hit;

    // builder to active bank
    hist_bank_if bank_if ();

    frame_sequencer u_seq (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .pixel_idx   (pixel_idx),
        .last_sample (last_sample),
        .frame_done  (frame_done)
    );

    hist_builder u_builder (
        .clk         (clk),
        .combin_res  (combin_res),
        .wr_en       (wr_en),
        .bin_code    (bin_code),
        .pixel_idx   (pixel_idx),
        .bank        (bank_if.builder),
        .bin_count   (bin_count),
        .count_valid (count_valid)
    );

    hist_bank u_bank (
        .clk           (clk),
        .combin_res    (combin_res),
        .port          (bank_if.bank),
        .last_sample   (last_sample),
        .scan_addr     (scan_addr),
        .scan_rd_count (scan_rd_count),
        .scan_rd_hit   (scan_rd_hit),
        .his_num       (his_num)
    );

    hist_readout u_readout (
        .clk           (clk),
        .combin_res    (combin_res),
        .frame_done    (frame_done),
        .scan_addr     (scan_addr),
        .scan_rd_count (scan_rd_count),
        .scan_rd_hit   (scan_rd_hit),
        .scan_valid    (scan_valid),
        .scan_pixel    (scan_pixel),
        .scan_bin      (scan_bin),
        .scan_count    (scan_count),
        .peak_valid    (peak_valid),
        .peak_pixel    (peak_pixel),
        .peak_bin      (peak_bin),
        .peak_count    (peak_count)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

// free-running testbench clock, 40 ns period
module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        // half period
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule
